// ==== source/rv32_pkg.sv ====
package rv32_pkg;

    localparam int xlen = 32;

    // major opcodes of the supported subset.
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_fence  = 7'b0001111;

    typedef enum logic [1:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or
    } alu_op_t;

    // all zero is a bubble.
    typedef struct packed {
        alu_op_t    alu_op;
        logic       use_imm;
        logic       mem_read;
        logic       mem_write;
        logic       branch;
        logic       branch_ne;
        logic       fence;
        logic       rd_write;
        logic [4:0] rd;       // zero unless rd_write.
        logic [4:0] rs1;      // zero when not read.
        logic [4:0] rs2;
    } ctrl_t;

endpackage

// ==== source/rv32_pipe_ctrl_if.sv ====
`timescale 1ns/1ps

interface rv32_pipe_ctrl_if;
    logic fetch_stall;
    logic decode_stall;
    logic decode_flush;
    logic execute_stall;
    logic execute_flush;
    logic mem_stall;
    logic mem_flush;
    logic writeback_flush;

    modport hazard (
        output fetch_stall, decode_stall, decode_flush, execute_stall,
               execute_flush, mem_stall, mem_flush, writeback_flush
    );

    modport stage (
        input fetch_stall, decode_stall, decode_flush, execute_stall,
              execute_flush, mem_stall, mem_flush, writeback_flush
    );
endinterface

// ==== source/rv32_fetch.sv ====
`timescale 1ns/1ps

module rv32_fetch #(
    parameter logic [rv32_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                      clk,
    input  logic                      rst_n,
    rv32_pipe_ctrl_if.stage           ctrl,
    input  logic                      branch_mispredicted,
    input  logic [rv32_pkg::xlen-1:0] branch_target,
    output logic [rv32_pkg::xlen-1:0] instr_addr,
    output logic                      instr_read,
    input  logic                      instr_ready,
    input  logic [rv32_pkg::xlen-1:0] instr_rdata,
    output logic [rv32_pkg::xlen-1:0] fd_pc,
    output logic [rv32_pkg::xlen-1:0] fd_instr,
    output logic                      fd_valid
);
    logic [rv32_pkg::xlen-1:0] pc;
    logic [rv32_pkg::xlen-1:0] redirect_pc;
    logic                      redirect_valid;
    logic                      fetch_done;
    logic                      in_flight;

    assign fetch_done = instr_read && instr_ready;
    assign in_flight  = instr_read && !instr_ready;
    assign instr_addr = pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc             <= reset_pc;
            instr_read     <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            instr_read <= 1'b1;
            if (branch_mispredicted && in_flight) begin
                // address must stay put until the pending access completes.
                redirect_valid <= 1'b1;
                redirect_pc    <= branch_target;
            end else if (branch_mispredicted) begin
                pc             <= branch_target;
                redirect_valid <= 1'b0;
            end else if (redirect_valid && fetch_done) begin
                pc             <= redirect_pc;
                redirect_valid <= 1'b0;
            end else if (fetch_done && !ctrl.fetch_stall) begin
                pc <= pc + 32'd4;
            end
        end
    end

    // a word fetched while the pc is held is fetched again later.
    always_ff @(posedge clk) begin
        if (!rst_n || ctrl.decode_flush) begin
            fd_valid <= 1'b0;
        end else if (!ctrl.decode_stall) begin
            fd_valid <= fetch_done && !redirect_valid && !ctrl.fetch_stall;
        end
    end

    always_ff @(posedge clk) begin
        if (!ctrl.decode_stall) begin
            fd_pc    <= pc;
            fd_instr <= instr_rdata;
        end
    end
endmodule

// ==== source/rv32_decode.sv ====
`timescale 1ns/1ps

module rv32_decode (
    input  logic                      clk,
    input  logic                      rst_n,
    rv32_pipe_ctrl_if.stage           ctrl,
    input  logic [rv32_pkg::xlen-1:0] fd_pc,
    input  logic [rv32_pkg::xlen-1:0] fd_instr,
    input  logic                      fd_valid,
    input  logic                      wb_write,
    input  logic [4:0]                wb_rd,
    input  logic [rv32_pkg::xlen-1:0] wb_data,
    output logic [4:0]                rs1_unreg,
    output logic                      rs1_read_unreg,
    output logic [4:0]                rs2_unreg,
    output logic                      rs2_read_unreg,
    output logic                      fence_unreg,
    output rv32_pkg::ctrl_t           de_ctrl,
    output logic [rv32_pkg::xlen-1:0] de_pc,
    output logic [rv32_pkg::xlen-1:0] de_rs1_value,
    output logic [rv32_pkg::xlen-1:0] de_rs2_value,
    output logic [rv32_pkg::xlen-1:0] de_imm
);
    logic [rv32_pkg::xlen-1:0] regs [1:31];
    rv32_pkg::ctrl_t           dec;
    logic [6:0]                opcode;
    logic [2:0]                funct3;
    logic                      rs1_read;
    logic                      rs2_read;
    logic [rv32_pkg::xlen-1:0] imm;
    logic [rv32_pkg::xlen-1:0] rs1_value;
    logic [rv32_pkg::xlen-1:0] rs2_value;

    assign opcode = fd_instr[6:0];
    assign funct3 = fd_instr[14:12];

    always_comb begin
        dec      = '0;
        rs1_read = 1'b0;
        rs2_read = 1'b0;
        if (fd_valid) begin
            case (opcode)
                rv32_pkg::op_reg: begin
                    rs1_read     = 1'b1;
                    rs2_read     = 1'b1;
                    dec.rd_write = 1'b1;
                    case (funct3)
                        3'b000:  dec.alu_op = fd_instr[30] ? rv32_pkg::alu_sub : rv32_pkg::alu_add;
                        3'b110:  dec.alu_op = rv32_pkg::alu_or;
                        3'b111:  dec.alu_op = rv32_pkg::alu_and;
                        default: dec.rd_write = 1'b0;
                    endcase
                end
                rv32_pkg::op_imm: begin
                    rs1_read     = 1'b1;
                    dec.use_imm  = 1'b1;
                    dec.rd_write = (funct3 == 3'b000); // addi only.
                end
                rv32_pkg::op_load: begin
                    rs1_read     = 1'b1;
                    dec.use_imm  = 1'b1;
                    dec.mem_read = (funct3 == 3'b010);
                    dec.rd_write = (funct3 == 3'b010);
                end
                rv32_pkg::op_store: begin
                    rs1_read      = 1'b1;
                    rs2_read      = 1'b1;
                    dec.use_imm   = 1'b1;
                    dec.mem_write = (funct3 == 3'b010);
                end
                rv32_pkg::op_branch: begin
                    rs1_read      = 1'b1;
                    rs2_read      = 1'b1;
                    dec.branch    = (funct3[2:1] == 2'b00);
                    dec.branch_ne = funct3[0];
                end
                rv32_pkg::op_fence: dec.fence = 1'b1;
                default: ;  // unknown opcodes fall through as bubbles.
            endcase
        end
        dec.rs1 = rs1_read ? fd_instr[19:15] : 5'd0;
        dec.rs2 = rs2_read ? fd_instr[24:20] : 5'd0;
        dec.rd  = dec.rd_write ? fd_instr[11:7] : 5'd0;
    end

    always_comb begin
        case (opcode)
            rv32_pkg::op_store:  imm = {{20{fd_instr[31]}}, fd_instr[31:25], fd_instr[11:7]};
            rv32_pkg::op_branch: imm = {{19{fd_instr[31]}}, fd_instr[31], fd_instr[7],
                                        fd_instr[30:25], fd_instr[11:8], 1'b0};
            default:             imm = {{20{fd_instr[31]}}, fd_instr[31:20]};
        endcase
    end

    assign rs1_unreg      = dec.rs1;
    assign rs1_read_unreg = rs1_read;
    assign rs2_unreg      = dec.rs2;
    assign rs2_read_unreg = rs2_read;
    assign fence_unreg    = dec.fence;

    // write-first, so a same-cycle writeback is seen.
    assign rs1_value = (dec.rs1 == 5'd0) ? '0 :
                       (wb_write && wb_rd == dec.rs1) ? wb_data : regs[dec.rs1];
    assign rs2_value = (dec.rs2 == 5'd0) ? '0 :
                       (wb_write && wb_rd == dec.rs2) ? wb_data : regs[dec.rs2];

    always_ff @(posedge clk) begin
        if (wb_write && wb_rd != 5'd0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || ctrl.execute_flush) begin
            de_ctrl <= '0;
        end else if (!ctrl.execute_stall) begin
            de_ctrl <= dec;
        end
    end

    always_ff @(posedge clk) begin
        if (!ctrl.execute_stall) begin
            de_pc        <= fd_pc;
            de_imm       <= imm;
            de_rs1_value <= rs1_value;
            de_rs2_value <= rs2_value;
        end else begin
            // while held, pick up results that retire past us.
            if (wb_write && wb_rd != 5'd0 && wb_rd == de_ctrl.rs1) de_rs1_value <= wb_data;
            if (wb_write && wb_rd != 5'd0 && wb_rd == de_ctrl.rs2) de_rs2_value <= wb_data;
        end
    end
endmodule

// ==== source/rv32_execute.sv ====
`timescale 1ns/1ps

module rv32_execute (
    input  logic                      clk,
    input  logic                      rst_n,
    rv32_pipe_ctrl_if.stage           ctrl,
    input  rv32_pkg::ctrl_t           de_ctrl,
    input  logic [rv32_pkg::xlen-1:0] de_pc,
    input  logic [rv32_pkg::xlen-1:0] de_rs1_value,
    input  logic [rv32_pkg::xlen-1:0] de_rs2_value,
    input  logic [rv32_pkg::xlen-1:0] de_imm,
    input  logic [4:0]                em_ctrl_fwd_rd,
    input  logic [rv32_pkg::xlen-1:0] em_fwd_value,
    input  logic [4:0]                mw_fwd_rd,
    input  logic [rv32_pkg::xlen-1:0] mw_fwd_value,
    output logic                      branch_mispredicted,
    output logic [rv32_pkg::xlen-1:0] branch_target,
    output rv32_pkg::ctrl_t           em_ctrl,
    output logic [rv32_pkg::xlen-1:0] em_result,
    output logic [rv32_pkg::xlen-1:0] em_store_value
);
    logic [rv32_pkg::xlen-1:0] rs1_fwd;
    logic [rv32_pkg::xlen-1:0] rs2_fwd;
    logic [rv32_pkg::xlen-1:0] op_b;
    logic [rv32_pkg::xlen-1:0] alu_result;

    // newest producer wins; rd is zero for anything that does not write.
    function automatic logic [rv32_pkg::xlen-1:0] forward(
        input logic [4:0]                rs,
        input logic [rv32_pkg::xlen-1:0] reg_value
    );
        if (rs != 5'd0 && rs == em_ctrl_fwd_rd) return em_fwd_value;
        if (rs != 5'd0 && rs == mw_fwd_rd) return mw_fwd_value;
        return reg_value;
    endfunction

    assign rs1_fwd = forward(de_ctrl.rs1, de_rs1_value);
    assign rs2_fwd = forward(de_ctrl.rs2, de_rs2_value);
    assign op_b    = de_ctrl.use_imm ? de_imm : rs2_fwd;

    always_comb begin
        case (de_ctrl.alu_op)
            rv32_pkg::alu_sub: alu_result = rs1_fwd - op_b;
            rv32_pkg::alu_and: alu_result = rs1_fwd & op_b;
            rv32_pkg::alu_or:  alu_result = rs1_fwd | op_b;
            default:           alu_result = rs1_fwd + op_b; // also load/store address.
        endcase
    end

    assign branch_target       = de_pc + de_imm;
    assign branch_mispredicted = de_ctrl.branch && ((rs1_fwd == rs2_fwd) ^ de_ctrl.branch_ne);

    always_ff @(posedge clk) begin
        if (!rst_n || ctrl.mem_flush) begin
            em_ctrl <= '0;
        end else if (!ctrl.mem_stall) begin
            em_ctrl <= de_ctrl;
        end
    end

    always_ff @(posedge clk) begin
        if (!ctrl.mem_stall) begin
            em_result      <= alu_result;
            em_store_value <= rs2_fwd;
        end
    end
endmodule

// ==== source/rv32_memory_stage.sv ====
`timescale 1ns/1ps

module rv32_memory_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    rv32_pipe_ctrl_if.stage           ctrl,
    input  rv32_pkg::ctrl_t           em_ctrl,
    input  logic [rv32_pkg::xlen-1:0] em_result,
    input  logic [rv32_pkg::xlen-1:0] em_store_value,
    output logic [rv32_pkg::xlen-1:0] data_addr,
    output logic                      data_read,
    output logic                      data_write,
    output logic [rv32_pkg::xlen-1:0] data_wdata,
    input  logic                      data_ready,
    input  logic [rv32_pkg::xlen-1:0] data_rdata,
    output logic                      wb_write,
    output logic [4:0]                wb_rd,
    output logic [rv32_pkg::xlen-1:0] wb_data
);
    logic [rv32_pkg::xlen-1:0] load_data;

    // word accesses only, the low address bits are dropped.
    assign data_addr  = {em_result[rv32_pkg::xlen-1:2], 2'b00};
    assign data_read  = em_ctrl.mem_read;
    assign data_write = em_ctrl.mem_write;
    assign data_wdata = em_store_value;

    assign load_data = data_rdata;

    always_ff @(posedge clk) begin
        if (!rst_n || ctrl.writeback_flush) begin
            wb_write <= 1'b0;
            wb_rd    <= 5'd0;
        end else begin
            wb_write <= em_ctrl.rd_write;
            wb_rd    <= em_ctrl.rd;
        end
    end

    // rdata is only valid with ready; otherwise the flush above drops this word.
    always_ff @(posedge clk) begin
        if (em_ctrl.mem_read && data_ready) begin
            wb_data <= load_data;
        end else begin
            wb_data <= em_result;
        end
    end
endmodule

// ==== source/rv32_hazard_unit.sv ====
`timescale 1ns/1ps

module rv32_hazard_unit (
    input  logic             [4:0] rs1_unreg,
    input  logic             rs1_read_unreg,
    input  logic             [4:0] rs2_unreg,
    input  logic             rs2_read_unreg,
    input  logic             fence_unreg,
    input  logic             de_mem_read,
    input  logic             de_fence,
    input  logic [4:0]       de_rd,
    input  logic             de_rd_write,
    input  logic             em_fence,
    input  logic             branch_mispredicted,
    input  logic             instr_read,
    input  logic             instr_ready,
    input  logic             data_read,
    input  logic             data_write,
    input  logic             data_ready,
    rv32_pipe_ctrl_if.hazard ctrl
);
    logic load_use;
    logic instr_wait;
    logic data_wait;
    logic fence_busy;

    assign load_use   = de_mem_read && de_rd_write && de_rd != 5'd0 &&
                        ((rs1_read_unreg && rs1_unreg == de_rd) ||
                         (rs2_read_unreg && rs2_unreg == de_rd));
    assign instr_wait = instr_read && !instr_ready;
    assign data_wait  = (data_read || data_write) && !data_ready;
    assign fence_busy = fence_unreg || de_fence || em_fence;

    assign ctrl.fetch_stall     = load_use || instr_wait || fence_busy || data_wait;
    assign ctrl.decode_stall    = load_use || data_wait;
    assign ctrl.decode_flush    = branch_mispredicted;
    assign ctrl.execute_stall   = data_wait;
    // the load must not be dropped while the data bus holds everything.
    assign ctrl.execute_flush   = branch_mispredicted || (load_use && !data_wait);
    assign ctrl.mem_stall       = data_wait;
    assign ctrl.mem_flush       = 1'b0;
    assign ctrl.writeback_flush = data_wait; // stalled access leaves a bubble behind.
endmodule

// ==== source/rv32_core.sv ====
`timescale 1ns/1ps

module rv32_core #(
    parameter logic [rv32_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                      clk,
    input  logic                      rst_n,
    output logic [rv32_pkg::xlen-1:0] instr_addr,
    output logic                      instr_read,
    input  logic                      instr_ready,
    input  logic [rv32_pkg::xlen-1:0] instr_rdata,
    output logic [rv32_pkg::xlen-1:0] data_addr,
    output logic                      data_read,
    output logic                      data_write,
    output logic [rv32_pkg::xlen-1:0] data_wdata,
    input  logic                      data_ready,
    input  logic [rv32_pkg::xlen-1:0] data_rdata
);
    logic                      branch_mispredicted;
    logic [rv32_pkg::xlen-1:0] branch_target;
    logic [rv32_pkg::xlen-1:0] fd_pc;
    logic [rv32_pkg::xlen-1:0] fd_instr;
    logic                      fd_valid;
    logic                      wb_write;
    logic [4:0]                wb_rd;
    logic [rv32_pkg::xlen-1:0] wb_data;
    logic [4:0]                rs1_unreg;
    logic                      rs1_read_unreg;
    logic [4:0]                rs2_unreg;
    logic                      rs2_read_unreg;
    logic                      fence_unreg;
    rv32_pkg::ctrl_t           de_ctrl;
    rv32_pkg::ctrl_t           em_ctrl;
    logic [rv32_pkg::xlen-1:0] de_pc;
    logic [rv32_pkg::xlen-1:0] de_rs1_value;
    logic [rv32_pkg::xlen-1:0] de_rs2_value;
    logic [rv32_pkg::xlen-1:0] de_imm;
    logic [rv32_pkg::xlen-1:0] em_result;
    logic [rv32_pkg::xlen-1:0] em_store_value;

    rv32_pipe_ctrl_if ctrl ();

    rv32_fetch #(.reset_pc(reset_pc)) fetch (
        .clk(clk), .rst_n(rst_n), .ctrl(ctrl),
        .branch_mispredicted(branch_mispredicted), .branch_target(branch_target),
        .instr_addr(instr_addr), .instr_read(instr_read),
        .instr_ready(instr_ready), .instr_rdata(instr_rdata),
        .fd_pc(fd_pc), .fd_instr(fd_instr), .fd_valid(fd_valid)
    );

    rv32_decode decode (
        .clk(clk), .rst_n(rst_n), .ctrl(ctrl),
        .fd_pc(fd_pc), .fd_instr(fd_instr), .fd_valid(fd_valid),
        .wb_write(wb_write), .wb_rd(wb_rd), .wb_data(wb_data),
        .rs1_unreg(rs1_unreg), .rs1_read_unreg(rs1_read_unreg),
        .rs2_unreg(rs2_unreg), .rs2_read_unreg(rs2_read_unreg),
        .fence_unreg(fence_unreg),
        .de_ctrl(de_ctrl), .de_pc(de_pc), .de_rs1_value(de_rs1_value),
        .de_rs2_value(de_rs2_value), .de_imm(de_imm)
    );

    rv32_execute execute (
        .clk(clk), .rst_n(rst_n), .ctrl(ctrl),
        .de_ctrl(de_ctrl), .de_pc(de_pc), .de_rs1_value(de_rs1_value),
        .de_rs2_value(de_rs2_value), .de_imm(de_imm),
        .em_ctrl_fwd_rd(em_ctrl.rd), .em_fwd_value(em_result),
        .mw_fwd_rd(wb_rd), .mw_fwd_value(wb_data),
        .branch_mispredicted(branch_mispredicted), .branch_target(branch_target),
        .em_ctrl(em_ctrl), .em_result(em_result), .em_store_value(em_store_value)
    );

    rv32_memory_stage memory (
        .clk(clk), .rst_n(rst_n), .ctrl(ctrl),
        .em_ctrl(em_ctrl), .em_result(em_result), .em_store_value(em_store_value),
        .data_addr(data_addr), .data_read(data_read), .data_write(data_write),
        .data_wdata(data_wdata), .data_ready(data_ready), .data_rdata(data_rdata),
        .wb_write(wb_write), .wb_rd(wb_rd), .wb_data(wb_data)
    );

    rv32_hazard_unit hazard (
        .rs1_unreg(rs1_unreg), .rs1_read_unreg(rs1_read_unreg),
        .rs2_unreg(rs2_unreg), .rs2_read_unreg(rs2_read_unreg),
        .fence_unreg(fence_unreg),
        .de_mem_read(de_ctrl.mem_read), .de_fence(de_ctrl.fence),
        .de_rd(de_ctrl.rd), .de_rd_write(de_ctrl.rd_write),
        .em_fence(em_ctrl.fence),
        .branch_mispredicted(branch_mispredicted),
        .instr_read(instr_read), .instr_ready(instr_ready),
        .data_read(data_read), .data_write(data_write), .data_ready(data_ready),
        .ctrl(ctrl)
    );
endmodule

// ==== verification/rv32_core_tb.sv ====
`timescale 1ns/1ps

module rv32_core_tb;
    localparam int          cycles_per_task = 2000;
    localparam int          task_runs       = 7;
    localparam int          watchdog_cycles = task_runs * (cycles_per_task + 24) + 100;
    localparam logic [31:0] marker_addr     = 32'h0000_03fc;
    localparam logic [31:0] fence_addr      = 32'h0000_0140;

    logic        clk;
    logic        rst_n;
    logic [31:0] instr_addr;
    logic        instr_read;
    logic        instr_ready;
    logic [31:0] instr_rdata;
    logic [31:0] data_addr;
    logic        data_read;
    logic        data_write;
    logic [31:0] data_wdata;
    logic        data_ready;
    logic [31:0] data_rdata;

    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:255];
    logic [63:0] write_log [$];  // {addr, data} per completed write.
    logic [63:0] exp_writes [$];
    logic [31:0] rng_state;
    logic        waits_on;
    logic        marker_seen;
    logic        i_busy;
    logic        d_busy;
    int          i_wait;
    int          d_wait;
    int          prog_len;
    int          errors;
    int          checks;
    int          cycle;
    int          fence_write_cycle;
    int          fence_read_cycle;

    rv32_core #(.reset_pc(32'h0000_0000)) UUT (
        .clk(clk), .rst_n(rst_n),
        .instr_addr(instr_addr), .instr_read(instr_read),
        .instr_ready(instr_ready), .instr_rdata(instr_rdata),
        .data_addr(data_addr), .data_read(data_read), .data_write(data_write),
        .data_wdata(data_wdata), .data_ready(data_ready), .data_rdata(data_rdata)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int pick_wait();
        if (!waits_on) return 0;
        rng_state = xorshift(rng_state);
        return int'(rng_state[1:0]);
    endfunction

    function automatic logic [31:0] fill_word(input int i);
        return 32'h5a00_0000 ^ (32'(i) * 32'h0101_0101);
    endfunction

    // instruction encoders for the supported subset.
    function automatic logic [31:0] reg_word(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv32_pkg::op_reg};
    endfunction

    function automatic logic [31:0] add_word(input logic [4:0] rd, rs1, rs2);
        return reg_word(7'h00, rs2, rs1, 3'b000, rd);
    endfunction

    function automatic logic [31:0] sub_word(input logic [4:0] rd, rs1, rs2);
        return reg_word(7'h20, rs2, rs1, 3'b000, rd);
    endfunction

    function automatic logic [31:0] and_word(input logic [4:0] rd, rs1, rs2);
        return reg_word(7'h00, rs2, rs1, 3'b111, rd);
    endfunction

    function automatic logic [31:0] or_word(input logic [4:0] rd, rs1, rs2);
        return reg_word(7'h00, rs2, rs1, 3'b110, rd);
    endfunction

    function automatic logic [31:0] addi_word(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, rv32_pkg::op_imm};
    endfunction

    function automatic logic [31:0] lw_word(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, rv32_pkg::op_load};
    endfunction

    function automatic logic [31:0] sw_word(input logic [4:0] rs2, rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv32_pkg::op_store};
    endfunction

    function automatic logic [31:0] branch_word(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                                input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv32_pkg::op_branch};
    endfunction

    function automatic logic [31:0] fence_word();
        return {4'b0000, 4'b1111, 4'b1111, 5'd0, 3'b000, 5'd0, rv32_pkg::op_fence};
    endfunction

    // both bus slaves in one process so the wait draws keep a fixed order.
    always @(posedge clk) begin
        #1;
        if (instr_ready) i_busy = 1'b0;  // access completed at this edge.
        instr_ready = 1'b0;
        if (!instr_read) begin
            i_busy = 1'b0;
        end else begin
            if (!i_busy) begin
                i_busy = 1'b1;
                i_wait = pick_wait();
            end
            if (i_wait == 0) begin
                instr_ready = 1'b1;
                instr_rdata = imem[instr_addr[9:2]];
            end else begin
                i_wait = i_wait - 1;
            end
        end
        if (data_ready) d_busy = 1'b0;
        data_ready = 1'b0;
        if (!(data_read || data_write)) begin
            d_busy = 1'b0;
        end else begin
            if (!d_busy) begin
                d_busy = 1'b1;
                d_wait = pick_wait();
            end
            if (d_wait == 0) begin
                data_ready = 1'b1;
                data_rdata = dmem[data_addr[9:2]];
            end else begin
                d_wait = d_wait - 1;
            end
        end
    end

    // request and ready are stable here; a write completes at the next edge.
    always @(negedge clk) begin
        cycle = cycle + 1;
        if (rst_n && data_write && data_ready) begin
            dmem[data_addr[9:2]] = data_wdata;
            write_log.push_back({data_addr, data_wdata});
            if (data_addr == marker_addr) marker_seen = 1'b1;
            if (data_addr == fence_addr) fence_write_cycle = cycle;
        end
        if (rst_n && data_read && data_addr == fence_addr && fence_read_cycle == 0) begin
            fence_read_cycle = cycle;
        end
    end

    task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("** Error at %0t: %s: expected %h, got %h", $time, what, exp, got);
        end
    endtask

    task automatic expect_write(input logic [31:0] addr, input logic [31:0] data);
        exp_writes.push_back({addr, data});
    endtask

    task automatic emit(input logic [31:0] word);
        imem[prog_len] = word;
        prog_len++;
    endtask

    task automatic prepare_program();
        rst_n = 1'b0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = addi_word(5'd0, 5'd0, 12'(i));  // tagged nop.
            dmem[i] = fill_word(i);
        end
        write_log.delete();
        exp_writes.delete();
        prog_len          = 0;
        marker_seen       = 1'b0;
        fence_write_cycle = 0;
        fence_read_cycle  = 0;
    endtask

    task automatic compare_write_log(input string name);
        int n;
        n = (exp_writes.size() < write_log.size()) ? exp_writes.size() : write_log.size();
        checks++;
        assert (write_log.size() == exp_writes.size()) else begin
            errors++;
            $display("** Error at %0t: %s: expected %0d data writes, got %0d", $time, name,
                     exp_writes.size(), write_log.size());
        end
        for (int i = 0; i < n; i++) begin
            check_word($sformatf("%s write %0d address", name, i), write_log[i][63:32],
                       exp_writes[i][63:32]);
            check_word($sformatf("%s write %0d data", name, i), write_log[i][31:0],
                       exp_writes[i][31:0]);
            check_word($sformatf("%s memory word %0d", name, i), dmem[exp_writes[i][41:34]],
                       exp_writes[i][31:0]);
        end
    endtask

    task automatic run_program(input string name);
        int waited;
        emit(sw_word(5'd0, 5'd0, marker_addr[11:0]));
        emit(branch_word(3'b000, 5'd0, 5'd0, 13'd0));  // self-loop.
        expect_write(marker_addr, 32'h0000_0000);
        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;
        waited = 0;
        while (!marker_seen && waited < cycles_per_task) begin
            @(posedge clk);
            waited++;
        end
        #1;
        if (!marker_seen) begin
            errors++;
            $display("%s: timed out, the marker store did not appear within %0d cycles",
                     name, cycles_per_task);
        end
        compare_write_log(name);
    endtask

    task automatic alu_chain();
        logic [31:0] r [0:7];
        r[0] = 32'd0;                 // addi to x0 is discarded.
        r[1] = 32'd85;
        r[2] = r[1] + 32'hffff_fffd;  // -3 sign extended.
        r[3] = r[1] + r[2];
        r[4] = r[2] - r[3];
        r[5] = r[4] & r[3];
        r[6] = r[5] | r[2];
        r[7] = r[0] + r[1];
        prepare_program();
        emit(addi_word(5'd1, 5'd0, 12'd85));
        emit(addi_word(5'd2, 5'd1, 12'hffd));
        emit(add_word(5'd3, 5'd1, 5'd2));
        emit(sub_word(5'd4, 5'd2, 5'd3));
        emit(and_word(5'd5, 5'd4, 5'd3));
        emit(or_word(5'd6, 5'd5, 5'd2));
        emit(addi_word(5'd0, 5'd0, 12'd7));
        emit(add_word(5'd7, 5'd0, 5'd1));
        for (int k = 0; k < 8; k++) begin
            emit(sw_word(5'(k), 5'd0, 12'(12'h100 + 4 * k)));
            expect_write(32'h100 + 32'(4 * k), r[k]);
        end
        run_program("alu chain");
    endtask

    task automatic load_use();
        logic [31:0] loaded;
        logic [31:0] other;
        loaded = 32'h1234_5678;
        other  = 32'h0000_0111;
        prepare_program();
        dmem[32] = loaded;  // word at 0x80.
        emit(addi_word(5'd1, 5'd0, 12'h080));
        emit(addi_word(5'd2, 5'd0, 12'h111));
        emit(lw_word(5'd3, 5'd1, 12'h000));
        emit(add_word(5'd4, 5'd3, 5'd2));
        emit(sw_word(5'd4, 5'd0, 12'h100));
        expect_write(32'h0000_0100, loaded + other);
        run_program("load use");
    endtask

    task automatic branch_skip();
        prepare_program();
        emit(addi_word(5'd1, 5'd0, 12'd9));
        emit(addi_word(5'd2, 5'd0, 12'd9));
        emit(branch_word(3'b000, 5'd1, 5'd2, 13'd12));  // beq, taken.
        emit(sw_word(5'd1, 5'd0, 12'h100));
        emit(sw_word(5'd2, 5'd0, 12'h104));
        emit(addi_word(5'd3, 5'd0, 12'd1));
        emit(branch_word(3'b001, 5'd1, 5'd2, 13'd12));  // bne, falls through.
        emit(sw_word(5'd3, 5'd0, 12'h108));
        emit(sw_word(5'd1, 5'd0, 12'h10c));
        expect_write(32'h0000_0108, 32'd1);
        expect_write(32'h0000_010c, 32'd9);
        run_program("branches");
        check_word("branches skipped word 0x100", dmem[64], fill_word(64));
        check_word("branches skipped word 0x104", dmem[65], fill_word(65));
    endtask

    task automatic fence_order();
        prepare_program();
        emit(addi_word(5'd1, 5'd0, 12'h2a5));
        emit(sw_word(5'd1, 5'd0, fence_addr[11:0]));
        emit(fence_word());
        emit(lw_word(5'd2, 5'd0, fence_addr[11:0]));
        emit(sw_word(5'd2, 5'd0, 12'h144));
        expect_write(fence_addr, 32'h0000_02a5);
        expect_write(32'h0000_0144, 32'h0000_02a5);
        run_program("fence");
        checks++;
        // the fence holds fetch, so the load trails the store by more than its own slot.
        assert (fence_write_cycle != 0 && fence_read_cycle > fence_write_cycle + 2) else begin
            errors++;
            $display("fence: the load of 0x140 was not held back behind the store to it");
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        instr_ready = 1'b0;
        instr_rdata = 32'h0000_0000;
        data_ready  = 1'b0;
        data_rdata  = 32'h0000_0000;
        rng_state   = 32'hc059_61ab;
        waits_on    = 1'b0;
        marker_seen = 1'b0;
        i_busy      = 1'b0;
        d_busy      = 1'b0;
        i_wait      = 0;
        d_wait      = 0;
        errors      = 0;
        checks      = 0;
        cycle       = 0;
        alu_chain();
        load_use();
        branch_skip();
        fence_order();
        waits_on = 1'b1;  // same programs under random wait states.
        alu_chain();
        load_use();
        branch_skip();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdog_cycles * 100);
        $display("watchdog: the run exceeded %0d cycles and was stopped", watchdog_cycles);
        $display("Simulation FAILED");
        $finish;
    end
endmodule

// ==== build.f ====
source/rv32_pkg.sv
source/rv32_pipe_ctrl_if.sv
source/rv32_fetch.sv
source/rv32_decode.sv
source/rv32_execute.sv
source/rv32_memory_stage.sv
source/rv32_hazard_unit.sv
source/rv32_core.sv
verification/rv32_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

rm -rf obj_dir
verilator --binary --timing --assert -f build.f --top-module rv32_core_tb -o rv32_core_tb
./obj_dir/rv32_core_tb > sim.log 2>&1
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi
exit 0
